// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= adc_interface_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/adc_apb_regs.sv
`timescale 1ns/1ps

module adc_apb_regs (
  input  logic                           fclk_ctr_clk,
  input  logic                           rst,
  input  adc_if_pkg::apb_req_t           apb_req_i,
  output adc_if_pkg::apb_rsp_t           apb_rsp_o,
  input  logic [adc_if_pkg::CNT_W-1:0]   frame_cnt_i,
  input  logic [adc_if_pkg::CNT_W-1:0]   frame_err_cnt_i,
  input  adc_if_pkg::snap_status_t       snap_status_i,
  input  adc_if_pkg::frame_t             snap_rd_data_i,
  output logic [adc_if_pkg::SNAP_AW-1:0] snap_rd_idx_o,
  output adc_if_pkg::lane_slip_t         lane_slip_o,
  output logic                           frame_slip_o,
  output logic                           snap_trig_o
);
  import adc_if_pkg::*;

  logic              access;
  logic              in_snap;
  logic              hit;
  logic              read_only;
  logic              err;
  logic              wr_ok;
  logic              ctrl_wr;
  logic [APB_DW-1:0] rd_data;
  logic [APB_DW-1:0] prdata_q;
  logic              pready_q;
  logic              pslverr_q;

  // First access cycle is the wait state
  assign access = apb_req_i.psel & apb_req_i.penable & ~pready_q;

  assign in_snap = (apb_req_i.paddr >= SNAP_BASE) &&
                   (apb_req_i.paddr < SNAP_BASE + APB_AW'(8 * SNAP_DEPTH));

  // Presented from setup onward so RAM data is ready during the wait
  assign snap_rd_idx_o = apb_req_i.paddr[SNAP_AW+2:3];

  always_comb begin
    rd_data   = '0;
    hit       = 1'b1;
    read_only = 1'b1;
    case (apb_req_i.paddr)
      REG_VERSION:   rd_data = IF_VERSION;
      REG_CTRL:      read_only = 1'b0;  // Pulse bits read back as zero
      REG_LANE_SLIP: begin
        rd_data   = APB_DW'(lane_slip_o);
        read_only = 1'b0;
      end
      REG_FRAME_CNT: rd_data = frame_cnt_i;
      REG_FRAME_ERR: rd_data = frame_err_cnt_i;
      REG_STATUS:    rd_data = APB_DW'(snap_status_i);
      default: begin
        hit = in_snap;
        if (apb_req_i.paddr[2]) begin
          rd_data = APB_DW'({snap_rd_data_i[3], snap_rd_data_i[2]});
        end else begin
          rd_data = APB_DW'({snap_rd_data_i[1], snap_rd_data_i[0]});
        end
      end
    endcase
  end

  assign err     = ~hit | (apb_req_i.pwrite & read_only);
  assign wr_ok   = access & apb_req_i.pwrite & ~err;
  assign ctrl_wr = wr_ok && (apb_req_i.paddr == REG_CTRL);

  always_ff @(posedge fclk_ctr_clk) begin
    if (rst) begin
      pready_q     <= 1'b0;
      pslverr_q    <= 1'b0;
      lane_slip_o  <= '0;
      frame_slip_o <= 1'b0;
      snap_trig_o  <= 1'b0;
    end else begin
      pready_q     <= access;  // High for one cycle after the wait
      pslverr_q    <= access & err;
      snap_trig_o  <= ctrl_wr & apb_req_i.pwdata[0];
      frame_slip_o <= ctrl_wr & apb_req_i.pwdata[1];
      if (wr_ok && (apb_req_i.paddr == REG_LANE_SLIP)) begin
        lane_slip_o <= apb_req_i.pwdata[$bits(lane_slip_t)-1:0];
      end
    end
  end

  always_ff @(posedge fclk_ctr_clk) begin
    if (access) begin
      prdata_q <= rd_data;
    end
  end

  assign apb_rsp_o.prdata  = prdata_q;
  assign apb_rsp_o.pready  = pready_q;
  assign apb_rsp_o.pslverr = pslverr_q;

endmodule

// File: rtl/adc_frame_capture.sv
`timescale 1ns/1ps

module adc_frame_capture (
  input  logic                           fclk_ctr_clk,
  input  logic                           rst,
  input  adc_if_pkg::frame_t             lane_sample_i,
  input  logic                           frame_tick_i,
  input  logic                           sync_i,
  input  logic                           snap_trig_i,
  input  logic                           snap_ext_trig_i,
  input  logic [adc_if_pkg::SNAP_AW-1:0] snap_rd_idx_i,
  output adc_if_pkg::frame_t             snap_rd_data_o,
  output adc_if_pkg::snap_status_t       snap_status_o,
  output adc_if_pkg::frame_t             frame_o,
  output logic                           frame_valid_o
);
  import adc_if_pkg::*;

  logic               sync_q;
  logic               ext_q;
  logic               armed_q;
  logic               pending_q;
  logic               busy_q;
  logic               done_q;
  logic               snap_busy;
  logic               trig;
  logic               snap_we;
  logic [SNAP_AW-1:0] wr_idx_q;
  logic [SNAP_AW-1:0] wr_addr;
  frame_t             snap_mem [SNAP_DEPTH];

  assign snap_busy = busy_q | pending_q;

  // Register trigger or external pin edge, ignored mid capture
  assign trig = (snap_trig_i | (snap_ext_trig_i & ~ext_q)) & ~snap_busy;

  // Pending capture starts at entry 0 with the next output frame
  assign snap_we = frame_valid_o & snap_busy;
  assign wr_addr = pending_q ? '0 : wr_idx_q;

  always_ff @(posedge fclk_ctr_clk) begin
    if (rst) begin
      sync_q        <= 1'b0;
      ext_q         <= 1'b0;
      armed_q       <= 1'b0;
      frame_valid_o <= 1'b0;
    end else begin
      sync_q        <= sync_i;
      ext_q         <= snap_ext_trig_i;
      frame_valid_o <= frame_tick_i & armed_q;
      if (sync_i && !sync_q) begin
        armed_q <= 1'b1;  // Sticky until reset
      end
    end
  end

  always_ff @(posedge fclk_ctr_clk) begin
    if (frame_tick_i && armed_q) begin
      frame_o <= lane_sample_i;
    end
  end

  always_ff @(posedge fclk_ctr_clk) begin
    if (rst) begin
      pending_q <= 1'b0;
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      wr_idx_q  <= '0;
    end else begin
      if (trig) begin
        pending_q <= 1'b1;
        done_q    <= 1'b0;
      end
      if (snap_we) begin
        if (pending_q) begin
          pending_q <= 1'b0;
          busy_q    <= 1'b1;
          wr_idx_q  <= SNAP_AW'(1);
        end else if (wr_idx_q == SNAP_AW'(SNAP_DEPTH - 1)) begin
          busy_q   <= 1'b0;  // Last entry written
          done_q   <= 1'b1;
          wr_idx_q <= '0;
        end else begin
          wr_idx_q <= wr_idx_q + 1'b1;
        end
      end
    end
  end

  // Snapshot RAM with registered read port
  always_ff @(posedge fclk_ctr_clk) begin
    if (snap_we) begin
      snap_mem[wr_addr] <= frame_o;
    end
    snap_rd_data_o <= snap_mem[snap_rd_idx_i];
  end

  assign snap_status_o.busy  = snap_busy;
  assign snap_status_o.done  = done_q;
  assign snap_status_o.armed = armed_q;

endmodule

// File: rtl/adc_frame_monitor.sv
`timescale 1ns/1ps

module adc_frame_monitor (
  input  logic                         fclk_ctr_clk,
  input  logic                         rst,
  input  adc_if_pkg::bit_pair_t        fclk_bits_i,
  input  logic                         slip_i,
  output logic                         frame_tick_o,
  output logic [adc_if_pkg::CNT_W-1:0] frame_cnt_o,
  output logic [adc_if_pkg::CNT_W-1:0] frame_err_cnt_o
);
  import adc_if_pkg::*;

  logic [SAMPLE_W-1:0] fhist_q;
  logic [SAMPLE_W-1:0] fhist_d;
  logic [PHASE_W-1:0]  phase_q;
  logic                word_done;
  logic                pattern_bad;

  assign fhist_d = {fhist_q[SAMPLE_W-3:0], fclk_bits_i.rise, fclk_bits_i.fall};

  // A slip on the last phase pushes the boundary one cycle later
  assign word_done   = (phase_q == PHASE_W'(PHASES - 1)) && !slip_i;
  assign pattern_bad = (fhist_d != FCLK_PATTERN);

  always_ff @(posedge fclk_ctr_clk) begin
    fhist_q <= fhist_d;
  end

  always_ff @(posedge fclk_ctr_clk) begin
    if (rst) begin
      phase_q      <= '0;
      frame_tick_o <= 1'b0;
    end else begin
      frame_tick_o <= word_done;
      if (slip_i) begin
        phase_q <= phase_q;  // Hold for one cycle, two bits
      end else if (word_done) begin
        phase_q <= '0;
      end else begin
        phase_q <= phase_q + 1'b1;
      end
    end
  end

  // Saturating frame and error counters
  always_ff @(posedge fclk_ctr_clk) begin
    if (rst) begin
      frame_cnt_o     <= '0;
      frame_err_cnt_o <= '0;
    end else if (word_done) begin
      if (frame_cnt_o != '1) begin
        frame_cnt_o <= frame_cnt_o + 1'b1;
      end
      if (pattern_bad && (frame_err_cnt_o != '1)) begin
        frame_err_cnt_o <= frame_err_cnt_o + 1'b1;
      end
    end
  end

endmodule

// File: rtl/adc_if_pkg.sv
package adc_if_pkg;

  localparam int NUM_LANES  = 4;
  localparam int SAMPLE_W   = 10;
  localparam int PHASES     = 5;    // Two bits arrive per clock
  localparam int PHASE_W    = 3;
  localparam int SLIP_W     = 4;    // Valid offsets 0 to 9
  localparam int SNAP_DEPTH = 32;
  localparam int SNAP_AW    = 5;
  localparam int APB_AW     = 10;
  localparam int APB_DW     = 32;
  localparam int CNT_W      = 32;

  localparam logic [APB_DW-1:0]   IF_VERSION   = 32'd1;
  localparam logic [SAMPLE_W-1:0] FCLK_PATTERN = 10'b11111_00000;  // MSB first

  // Register offsets
  localparam logic [APB_AW-1:0] REG_VERSION   = 10'h000;
  localparam logic [APB_AW-1:0] REG_CTRL      = 10'h004;
  localparam logic [APB_AW-1:0] REG_LANE_SLIP = 10'h008;
  localparam logic [APB_AW-1:0] REG_FRAME_CNT = 10'h00C;
  localparam logic [APB_AW-1:0] REG_FRAME_ERR = 10'h010;
  localparam logic [APB_AW-1:0] REG_STATUS    = 10'h014;
  localparam logic [APB_AW-1:0] SNAP_BASE     = 10'h100;  // Eight bytes per entry

  typedef struct packed {
    logic rise;  // Earlier bit, more significant
    logic fall;
  } bit_pair_t;

  typedef bit_pair_t [NUM_LANES-1:0] lane_bits_t;

  typedef logic [SAMPLE_W-1:0] sample_t;

  // Lane 0 in the low bits
  typedef sample_t [NUM_LANES-1:0] frame_t;

  typedef logic [NUM_LANES-1:0][SLIP_W-1:0] lane_slip_t;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic busy;   // Also high while a trigger waits for its first frame
    logic done;
    logic armed;
  } snap_status_t;

endpackage

// File: rtl/adc_interface_top.sv
`timescale 1ns/1ps

module adc_interface_top (
  input  logic                   fclk_ctr_clk,
  input  logic                   rst,
  input  logic                   sync_i,
  input  logic                   snapshot_ext_trigger_i,
  input  adc_if_pkg::lane_bits_t lane_bits_i,
  input  adc_if_pkg::bit_pair_t  fclk_bits_i,
  input  adc_if_pkg::apb_req_t   apb_req_i,
  output adc_if_pkg::frame_t     frame_o,
  output logic                   frame_valid_o,
  output adc_if_pkg::apb_rsp_t   apb_rsp_o
);
  import adc_if_pkg::*;

  frame_t             lane_sample;
  lane_slip_t         lane_slip;
  logic               frame_tick;
  logic [CNT_W-1:0]   frame_cnt;
  logic [CNT_W-1:0]   frame_err_cnt;
  logic               frame_slip_pulse;
  logic               snap_trig_pulse;
  snap_status_t       snap_status;
  logic [SNAP_AW-1:0] snap_rd_idx;
  frame_t             snap_rd_data;

  // Lanes share reset so their phase counters stay in step
  for (genvar g = 0; g < NUM_LANES; g++) begin : gen_lane
    adc_lane_deser adc_lane_deser_i (
      .fclk_ctr_clk (fclk_ctr_clk),
      .rst          (rst),
      .bits_i       (lane_bits_i[g]),
      .slip_i       (lane_slip[g]),
      .sample_o     (lane_sample[g])
    );
  end

  adc_frame_monitor adc_frame_monitor_i (
    .fclk_ctr_clk    (fclk_ctr_clk),
    .rst             (rst),
    .fclk_bits_i     (fclk_bits_i),
    .slip_i          (frame_slip_pulse),
    .frame_tick_o    (frame_tick),
    .frame_cnt_o     (frame_cnt),
    .frame_err_cnt_o (frame_err_cnt)
  );

  adc_frame_capture adc_frame_capture_i (
    .fclk_ctr_clk    (fclk_ctr_clk),
    .rst             (rst),
    .lane_sample_i   (lane_sample),
    .frame_tick_i    (frame_tick),
    .sync_i          (sync_i),
    .snap_trig_i     (snap_trig_pulse),
    .snap_ext_trig_i (snapshot_ext_trigger_i),
    .snap_rd_idx_i   (snap_rd_idx),
    .snap_rd_data_o  (snap_rd_data),
    .snap_status_o   (snap_status),
    .frame_o         (frame_o),
    .frame_valid_o   (frame_valid_o)
  );

  adc_apb_regs adc_apb_regs_i (
    .fclk_ctr_clk    (fclk_ctr_clk),
    .rst             (rst),
    .apb_req_i       (apb_req_i),
    .apb_rsp_o       (apb_rsp_o),
    .frame_cnt_i     (frame_cnt),
    .frame_err_cnt_i (frame_err_cnt),
    .snap_status_i   (snap_status),
    .snap_rd_data_i  (snap_rd_data),
    .snap_rd_idx_o   (snap_rd_idx),
    .lane_slip_o     (lane_slip),
    .frame_slip_o    (frame_slip_pulse),
    .snap_trig_o     (snap_trig_pulse)
  );

endmodule

// File: rtl/adc_lane_deser.sv
`timescale 1ns/1ps

module adc_lane_deser (
  input  logic                          fclk_ctr_clk,
  input  logic                          rst,
  input  adc_if_pkg::bit_pair_t         bits_i,
  input  logic [adc_if_pkg::SLIP_W-1:0] slip_i,
  output adc_if_pkg::sample_t           sample_o
);
  import adc_if_pkg::*;

  logic [2*SAMPLE_W-1:0] hist_q;
  logic [2*SAMPLE_W-1:0] hist_d;
  logic [2*SAMPLE_W-1:0] hist_shift;
  logic [PHASE_W-1:0]    phase_q;
  logic [SLIP_W-1:0]     slip_eff;
  logic                  word_done;

  // Newest bit lands in bit 0, rise ahead of fall
  assign hist_d = {hist_q[2*SAMPLE_W-3:0], bits_i.rise, bits_i.fall};

  // Offsets past the word width act as the largest offset
  assign slip_eff = (slip_i > SLIP_W'(SAMPLE_W - 1)) ? SLIP_W'(SAMPLE_W - 1) : slip_i;

  // Window starts slip_eff bits back from the newest bit
  assign hist_shift = hist_d >> slip_eff;

  assign word_done = (phase_q == PHASE_W'(PHASES - 1));

  // Free running, never held by a frame slip
  always_ff @(posedge fclk_ctr_clk) begin
    if (rst) begin
      phase_q <= '0;
    end else if (word_done) begin
      phase_q <= '0;
    end else begin
      phase_q <= phase_q + 1'b1;
    end
  end

  always_ff @(posedge fclk_ctr_clk) begin
    hist_q <= hist_d;
    if (word_done) begin
      sample_o <= hist_shift[SAMPLE_W-1:0];  // Valid alongside frame tick
    end
  end

endmodule

// File: sources.f
rtl/adc_if_pkg.sv
rtl/adc_lane_deser.sv
rtl/adc_frame_monitor.sv
rtl/adc_frame_capture.sv
rtl/adc_apb_regs.sv
rtl/adc_interface_top.sv
verif/adc_interface_tb.sv

// File: verif/adc_interface_tb.sv
`timescale 1ns/1ps

module adc_interface_tb;
  import adc_if_pkg::*;

  logic       fclk_ctr_clk = 1'b0;
  logic       rst = 1'b1;
  logic       sync_i = 1'b0;
  logic       snapshot_ext_trigger_i = 1'b0;
  lane_bits_t lane_bits_i = '0;
  bit_pair_t  fclk_bits_i = '0;
  apb_req_t   apb_req_i = '0;
  frame_t     frame_o;
  logic       frame_valid_o;
  apb_rsp_t   apb_rsp_o;

  integer              seed = 63;
  int                  neg_cnt = 0;
  int                  tb_phase = 0;     // Mirrors the DUT word phase
  frame_t              next_frame = '0;
  frame_t              cur_frame = '0;
  frame_t              prev_frame = '0;
  logic [SAMPLE_W-1:0] fclk_word = FCLK_PATTERN;
  logic [31:0]         line_q [NUM_LANES];  // Serial history per lane
  int                  lane_delay [NUM_LANES];
  int                  corrupt_req = 0;
  logic                check_en = 1'b0;
  logic                sync_sent = 1'b0;
  int                  tick_cnt = 0;     // Word boundaries sent by the model
  int                  last_valid_tick = 0;
  frame_t              obs_log [$];

  always #10 fclk_ctr_clk = ~fclk_ctr_clk;

  adc_interface_top adc_interface_top_i (
    .fclk_ctr_clk           (fclk_ctr_clk),
    .rst                    (rst),
    .sync_i                 (sync_i),
    .snapshot_ext_trigger_i (snapshot_ext_trigger_i),
    .lane_bits_i            (lane_bits_i),
    .fclk_bits_i            (fclk_bits_i),
    .apb_req_i              (apb_req_i),
    .frame_o                (frame_o),
    .frame_valid_o          (frame_valid_o),
    .apb_rsp_o              (apb_rsp_o)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_frame(input frame_t got, input frame_t exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_status(input snap_status_t got, input snap_status_t exp,
                              input string what);
    if (got !== exp) begin
      fail_run($sformatf("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  // MSB first serializer that runs one word ahead of the aligned stream
  always @(negedge fclk_ctr_clk) begin : drive_stream
    logic [31:0] r;
    if (rst) begin
      neg_cnt = neg_cnt + 1;
      if (neg_cnt == 3) rst = 1'b0;  // Three reset edges seen
    end
    if (!rst) begin
      if (tb_phase == 0) begin
        prev_frame = cur_frame;
        cur_frame = next_frame;
        for (int l = 0; l < NUM_LANES; l++) begin
          r = $random(seed);
          next_frame[l] = r[SAMPLE_W-1:0];
        end
        fclk_word = FCLK_PATTERN;
        r = $random(seed);
        if (corrupt_req > 0 && r[0]) begin
          fclk_word = FCLK_PATTERN ^ (r[SAMPLE_W:1] | 10'd1);  // Never zero
          corrupt_req = corrupt_req - 1;
        end
      end
      for (int l = 0; l < NUM_LANES; l++) begin
        line_q[l] = {line_q[l][29:0], next_frame[l][9-2*tb_phase],
                     next_frame[l][8-2*tb_phase]};
        // Lane word sits k bits back in the history at the boundary
        lane_bits_i[l].rise = line_q[l][SAMPLE_W+1-lane_delay[l]];
        lane_bits_i[l].fall = line_q[l][SAMPLE_W-lane_delay[l]];
      end
      fclk_bits_i.rise = fclk_word[9-2*tb_phase];
      fclk_bits_i.fall = fclk_word[8-2*tb_phase];
      if (tb_phase == PHASES - 1) tick_cnt = tick_cnt + 1;  // Boundary on the next rise
      tb_phase = (tb_phase == PHASES - 1) ? 0 : tb_phase + 1;
    end
  end

  // Output values are taken before the edge updates them
  always @(posedge fclk_ctr_clk) begin : observe
    if (frame_valid_o) begin
      if (!sync_sent) fail_run("frame_valid_o was high before any sync edge");
      obs_log.push_back(frame_o);
      if (check_en) begin
        check_frame(frame_o, prev_frame, "frame_o");
        check_word(32'(tick_cnt - last_valid_tick), 32'd1, "frames since last frame_valid_o");
      end
      last_valid_tick = tick_cnt;
    end
  end

  task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    int n;
    @(negedge fclk_ctr_clk);
    apb_req_i.psel    = 1'b1;
    apb_req_i.penable = 1'b0;
    apb_req_i.pwrite  = wr;
    apb_req_i.paddr   = addr;
    apb_req_i.pwdata  = wdata;
    @(negedge fclk_ctr_clk);
    apb_req_i.penable = 1'b1;
    n = 0;
    do begin
      @(negedge fclk_ctr_clk);
      n = n + 1;
      if (n > 20) fail_run("APB transfer got no pready within 20 cycles");
    end while (!apb_rsp_o.pready);
    rdata = apb_rsp_o.prdata;
    err = apb_rsp_o.pslverr;
    apb_req_i = '0;
  endtask

  task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] data);
    logic err;
    apb_xfer(1'b0, addr, 32'h0, data, err);
    check_word({31'b0, err}, 32'd0, "pslverr on read");
  endtask

  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    logic err;
    apb_xfer(1'b1, addr, data, unused, err);
    check_word({31'b0, err}, 32'd0, "pslverr on write");
  endtask

  task automatic wait_ticks(input int n);
    int start;
    int i;
    start = tick_cnt;
    i = 0;
    while (tick_cnt < start + n) begin
      @(negedge fclk_ctr_clk);
      i = i + 1;
      if (i > 10 * n + 20) fail_run("Timed out waiting for frame ticks");
    end
  endtask

  task automatic wait_frames(input int n);
    int start;
    int i;
    start = obs_log.size();
    i = 0;
    while (obs_log.size() < start + n) begin
      @(negedge fclk_ctr_clk);
      i = i + 1;
      if (i > 10 * n + 20) fail_run("Timed out waiting for frame_valid_o");
    end
  endtask

  task automatic run_snapshot(input logic use_pin);
    logic [31:0]  w0;
    logic [31:0]  w4;
    snap_status_t exp;
    frame_t       snap [SNAP_DEPTH];
    int           n0;
    int           s;
    int           polls;
    if (use_pin) begin
      @(negedge fclk_ctr_clk);
      snapshot_ext_trigger_i = 1'b1;
      n0 = obs_log.size();
    end else begin
      apb_write(REG_CTRL, 32'h1);
      n0 = obs_log.size();
    end
    exp = '{busy: 1'b1, done: 1'b0, armed: 1'b1};
    apb_read(REG_STATUS, w0);
    check_status(snap_status_t'(w0[2:0]), exp, "STATUS after trigger");
    apb_write(REG_CTRL, 32'h1);  // Ignored while busy
    polls = 0;
    do begin
      apb_read(REG_STATUS, w0);
      polls = polls + 1;
      if (polls > 300) fail_run("Snapshot never reported done");
    end while (!w0[1]);
    snapshot_ext_trigger_i = 1'b0;
    exp = '{busy: 1'b0, done: 1'b1, armed: 1'b1};
    check_status(snap_status_t'(w0[2:0]), exp, "STATUS after capture");
    for (int i = 0; i < SNAP_DEPTH; i++) begin
      apb_read(SNAP_BASE + APB_AW'(8 * i), w0);
      apb_read(SNAP_BASE + APB_AW'(8 * i + 4), w4);
      snap[i] = {w4[19:0], w0[19:0]};  // Lanes 3,2 then 1,0
    end
    s = (snap[0] === obs_log[n0]) ? n0 : n0 + 1;  // First or second frame after trigger
    for (int i = 0; i < SNAP_DEPTH; i++) begin
      check_frame(snap[i], obs_log[s+i], $sformatf("snapshot entry %0d", i));
    end
  endtask

  initial begin : test_seq
    logic [31:0] r;
    logic [31:0] d;
    logic [31:0] d2;
    logic        e;
    lane_slip_t  slip;
    int          m;
    int          t1;
    int          dd;
    for (int l = 0; l < NUM_LANES; l++) begin
      line_q[l] = '0;
      lane_delay[l] = 0;
    end
    m = 0;
    while (rst) begin
      @(negedge fclk_ctr_clk);
      m = m + 1;
      if (m > 10) fail_run("Reset never released");
    end

    apb_read(REG_VERSION, d);
    check_word(d, IF_VERSION, "VERSION");
    repeat (3) begin
      r = $random(seed);
      apb_write(REG_LANE_SLIP, {16'h0, r[15:0]});
      apb_read(REG_LANE_SLIP, d);
      check_word(d, {16'h0, r[15:0]}, "LANE_SLIP readback");
    end
    apb_write(REG_LANE_SLIP, 32'h0);
    apb_xfer(1'b0, 10'h018, 32'h0, d, e);
    check_word({31'b0, e}, 32'd1, "pslverr on unmapped read");
    apb_xfer(1'b1, REG_VERSION, 32'hff, d, e);
    check_word({31'b0, e}, 32'd1, "pslverr on VERSION write");
    apb_read(REG_VERSION, d);
    check_word(d, IF_VERSION, "VERSION after write");

    // Output starts at the sync edge with aligned lanes
    wait_ticks(3);
    @(negedge fclk_ctr_clk);
    sync_sent = 1'b1;
    sync_i = 1'b1;
    wait_frames(1);
    check_en = 1'b1;
    wait_frames(20);

    // Random per-lane delays matched by bit offsets
    check_en = 1'b0;
    for (int l = 0; l < NUM_LANES; l++) begin
      r = $random(seed);
      lane_delay[l] = int'(r % 10);
      slip[l] = SLIP_W'(lane_delay[l]);
    end
    apb_write(REG_LANE_SLIP, {16'h0, slip});
    wait_frames(2);
    check_en = 1'b1;
    wait_frames(20);

    // Frame clock errors and frame count
    apb_read(REG_FRAME_ERR, d);
    r = $random(seed);
    m = 1 + int'(r % 5);
    corrupt_req = m;
    t1 = 0;
    while (corrupt_req > 0) begin
      @(negedge fclk_ctr_clk);
      t1 = t1 + 1;
      if (t1 > 1000) fail_run("Corrupted frames were never sent");
    end
    wait_ticks(2);
    apb_read(REG_FRAME_ERR, d2);
    check_word(d2 - d, 32'(m), "FRAME_ERR increase");
    apb_read(REG_FRAME_CNT, d);
    t1 = tick_cnt;
    wait_ticks(7);
    apb_read(REG_FRAME_CNT, d2);
    dd = int'(d2 - d) - (tick_cnt - t1);
    if (dd > 1 || dd < -1) begin
      fail_run($sformatf("Error at %0t ns: FRAME_CNT rose by %0d over %0d ticks",
                         $time, d2 - d, tick_cnt - t1));
    end

    run_snapshot(1'b0);
    run_snapshot(1'b1);

    // Slip moves the monitor off the stream pattern
    check_en = 1'b0;
    apb_read(REG_FRAME_ERR, d);
    apb_write(REG_CTRL, 32'h2);
    wait_ticks(3);
    apb_read(REG_FRAME_ERR, d2);
    if (d2 <= d) fail_run("No pattern errors followed a frame slip");

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule
